/* run_sim.sh */
#!/usr/bin/env bash
# Build the covariance buffer read path with Verilator and run the testbench

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
  -f verilog.f --top-module tb_cb_read_top \
  --Mdir "$BUILD_DIR" -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -qx "Regression passed" "$LOG_FILE"; then
  exit 0
fi
echo "Pass message not found in $LOG_FILE"
exit 1

/* testbench/cb_read_top_chk.sv */
`timescale 1ns/1ns

module cb_read_top_chk (
  input  logic                     clk,
  input  logic                     sys_rst,
  input  logic                     i_cmd_req,
  input  logic                     o_cmd_ack,
  input  logic [cb_pkg::ROW_W-1:0] o_tb_dina,
  input  logic [cb_pkg::ROW_W-1:0] o_a_douta,
  input  logic [cb_pkg::ROW_W-1:0] o_b_douta,
  input  logic [cb_pkg::ROW_W-1:0] o_m_douta
);

  logic outs_zero;

  assign outs_zero = (o_tb_dina == '0) && (o_a_douta == '0) &&
                     (o_b_douta == '0) && (o_m_douta == '0);

  // Ack cleared by reset
  ack_in_reset: assert property (@(posedge clk) $past(sys_rst) |-> !o_cmd_ack)
    else $error("ack high while reset is asserted");

  ack_needs_req: assert property (@(posedge clk) disable iff (sys_rst)
    $rose(o_cmd_ack) |-> $past(i_cmd_req))
    else $error("ack rose without a request");

  // Ack holds for as long as req is up
  ack_holds: assert property (@(posedge clk) disable iff (sys_rst)
    ($past(o_cmd_ack) && $past(i_cmd_req)) |-> o_cmd_ack)
    else $error("ack fell while req was still high");

  zero_after_release: assert property (@(posedge clk) disable iff (sys_rst)
    ($past(o_cmd_ack, 3) && !$past(o_cmd_ack, 2)) |-> outs_zero)
    else $error("outputs not zero two cycles after ack fell");

endmodule

/* testbench/tb_cb_read_top.sv */
`timescale 1ns/1ns

module tb_cb_read_top;

  // Command budget of the whole run, used for the cycle limit
  localparam int N_CMDS = 848;
  localparam int N_WRITES = 264;
  localparam int TIMEOUT_CYC = N_CMDS * 20 + N_WRITES + 500;

  logic                                   clk;
  logic                                   sys_rst;
  logic                                   i_wr_en;
  logic [cb_pkg::CB_AW-1:0]               i_wr_addr;
  logic [cb_pkg::ROW_W-1:0]               i_wr_data;
  logic                                   i_cmd_req;
  logic [cb_pkg::CB_AW-1:0]               i_cmd_addr;
  logic [1:0]                             i_cmd_dest;
  logic [1:0]                             i_cmd_dir;
  logic                                   i_cmd_lk0;
  logic [cb_pkg::SEQ_CNT_DW-1:0]          i_cmd_seq;
  logic                                   o_cmd_ack;
  logic [cb_pkg::ROW_W-1:0]               o_tb_dina;
  logic [cb_pkg::ROW_W-1:0]               o_a_douta;
  logic [cb_pkg::ROW_W-1:0]               o_b_douta;
  logic [cb_pkg::ROW_W-1:0]               o_m_douta;

  // Testbench copy of the buffer contents
  logic [cb_pkg::ROW_W-1:0] shadow [cb_pkg::CB_DEPTH];

  logic [cb_pkg::ROW_W-1:0] exp_tb;
  logic [cb_pkg::ROW_W-1:0] exp_a;
  logic [cb_pkg::ROW_W-1:0] exp_b;
  logic [cb_pkg::ROW_W-1:0] exp_m;
  logic                     exp_valid = 1'b0;

  int cycle_cnt = 0;
  int cmp_count = 0;
  int cmp_err = 0;
  int seq_err = 0;
  int cmd_count = 0;
  int err_mark = 0;
  int cmd_mark = 0;

  cb_read_top UUT (
    .clk        (clk),
    .sys_rst    (sys_rst),
    .i_wr_en    (i_wr_en),
    .i_wr_addr  (i_wr_addr),
    .i_wr_data  (i_wr_data),
    .i_cmd_req  (i_cmd_req),
    .i_cmd_addr (i_cmd_addr),
    .i_cmd_dest (i_cmd_dest),
    .i_cmd_dir  (i_cmd_dir),
    .i_cmd_lk0  (i_cmd_lk0),
    .i_cmd_seq  (i_cmd_seq),
    .o_cmd_ack  (o_cmd_ack),
    .o_tb_dina  (o_tb_dina),
    .o_a_douta  (o_a_douta),
    .o_b_douta  (o_b_douta),
    .o_m_douta  (o_m_douta)
  );

  bind cb_read_top cb_read_top_chk u_chk (
    .clk       (clk),
    .sys_rst   (sys_rst),
    .i_cmd_req (i_cmd_req),
    .o_cmd_ack (o_cmd_ack),
    .o_tb_dina (o_tb_dina),
    .o_a_douta (o_a_douta),
    .o_b_douta (o_b_douta),
    .o_m_douta (o_m_douta)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT_CYC) begin
      $display("Timeout: run still busy after %0d clock cycles", cycle_cnt);
      $display("Regression failed");
      $finish;
    end
  end

  // Expected value of one output port for a command on a given row
  function automatic logic [cb_pkg::ROW_W-1:0] map_expect(
    input logic [1:0]                    out_dest,
    input logic [1:0]                    dest,
    input logic [1:0]                    dir,
    input logic                          lk0,
    input logic [cb_pkg::SEQ_CNT_DW-1:0] seq,
    input logic [cb_pkg::ROW_W-1:0]      row
  );
    logic [cb_pkg::RSA_DW-1:0] lane [4];
    logic [cb_pkg::RSA_DW-1:0] res [4];
    logic [cb_pkg::RSA_DW-1:0] p0;
    logic [cb_pkg::RSA_DW-1:0] p1;
    for (int k = 0; k < 4; k++) begin
      lane[k] = row[k*cb_pkg::RSA_DW +: cb_pkg::RSA_DW];
      res[k]  = '0;
    end
    p0 = lk0 ? lane[0] : lane[2];
    p1 = lk0 ? lane[1] : lane[3];
    if (out_dest == dest && dest == cb_pkg::DEST_TB) begin
      // Only new-landmark feeds the transfer buffer
      if (dir == cb_pkg::DIR_NEW) begin
        case (seq)
          10'd0: res[3] = p1;
          10'd1: res[0] = p0;
          10'd2: begin
            res[0] = p1;
            res[1] = p0;
          end
          10'd3: begin
            res[1] = p1;
            res[2] = p0;
          end
          10'd4: begin
            res[2] = p1;
            res[3] = p0;
          end
          default: res[0] = '0;
        endcase
      end
    end else if (out_dest == dest) begin
      for (int k = 0; k < 4; k++) begin
        if (dir == cb_pkg::DIR_POS) res[k] = lane[k];
        if (dir == cb_pkg::DIR_NEG) res[k] = lane[3-k];
      end
      if (dir == cb_pkg::DIR_NEW) begin
        res[0] = p0;
        res[1] = p1;
      end
    end
    return {res[3], res[2], res[1], res[0]};
  endfunction

  function automatic int mismatch(
    input string                    name,
    input logic [cb_pkg::ROW_W-1:0] got,
    input logic [cb_pkg::ROW_W-1:0] exp
  );
    if (got !== exp) begin
      $display("ERR t=%0t %s expected %h actual %h", $time, name, exp, got);
      return 1;
    end
    return 0;
  endfunction

  function automatic logic [cb_pkg::ROW_W-1:0] rand_row();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = $urandom;
    lo = $urandom;
    return {hi, lo};
  endfunction

  // Compares every output on each falling edge while ack is high
  always @(negedge clk) begin
    if (exp_valid && o_cmd_ack) begin
      cmp_count++;
      cmp_err += mismatch("o_tb_dina", o_tb_dina, exp_tb);
      cmp_err += mismatch("o_a_douta", o_a_douta, exp_a);
      cmp_err += mismatch("o_b_douta", o_b_douta, exp_b);
      cmp_err += mismatch("o_m_douta", o_m_douta, exp_m);
    end
  end

  task automatic write_row(
    input logic [cb_pkg::CB_AW-1:0] addr,
    input logic [cb_pkg::ROW_W-1:0] data
  );
    i_wr_en   = 1'b1;
    i_wr_addr = addr;
    i_wr_data = data;
    @(negedge clk);
    i_wr_en = 1'b0;
    shadow[addr] = data;
  endtask

  // One full four-phase command, starting and ending on a falling edge
  task automatic run_cmd(
    input logic [cb_pkg::CB_AW-1:0]      addr,
    input logic [1:0]                    dest,
    input logic [1:0]                    dir,
    input logic                          lk0,
    input logic [cb_pkg::SEQ_CNT_DW-1:0] seq,
    input logic [2:0]                    hold
  );
    int edges;
    int seen;
    exp_tb = map_expect(cb_pkg::DEST_TB, dest, dir, lk0, seq, shadow[addr]);
    exp_a  = map_expect(cb_pkg::DEST_A, dest, dir, lk0, seq, shadow[addr]);
    exp_b  = map_expect(cb_pkg::DEST_B, dest, dir, lk0, seq, shadow[addr]);
    exp_m  = map_expect(cb_pkg::DEST_M, dest, dir, lk0, seq, shadow[addr]);
    exp_valid = 1'b1;
    seen = cmp_count;
    cmd_count++;
    i_cmd_addr = addr;
    i_cmd_dest = dest;
    i_cmd_dir  = dir;
    i_cmd_lk0  = lk0;
    i_cmd_seq  = seq;
    i_cmd_req  = 1'b1;
    @(posedge clk);
    edges = 0;
    @(negedge clk);
    while (!o_cmd_ack) begin
      @(posedge clk);
      edges++;
      @(negedge clk);
    end
    if (edges != 3) begin
      $display("Handshake error at %0t: ack rose %0d edges after req, expected 3",
               $time, edges);
      seq_err++;
    end
    repeat (hold) @(negedge clk);
    i_cmd_req = 1'b0;
    edges = 0;
    while (o_cmd_ack) begin
      @(posedge clk);
      edges++;
      @(negedge clk);
    end
    if (edges != 2) begin
      $display("Handshake error at %0t: ack fell %0d edges after req dropped, expected 2",
               $time, edges);
      seq_err++;
    end
    exp_valid = 1'b0;
    // Ack stays up through the hold and one edge past the req drop
    if (cmp_count - seen != hold + 2) begin
      $display("At %0t ack was high for %0d falling edges, expected %0d",
               $time, cmp_count - seen, hold + 2);
      seq_err++;
    end
    // Outputs clear two edges after ack falls
    @(posedge clk);
    @(posedge clk);
    @(negedge clk);
    seq_err += mismatch("o_tb_dina", o_tb_dina, '0);
    seq_err += mismatch("o_a_douta", o_a_douta, '0);
    seq_err += mismatch("o_b_douta", o_b_douta, '0);
    seq_err += mismatch("o_m_douta", o_m_douta, '0);
  endtask

  task automatic start_test();
    err_mark = cmp_err + seq_err;
    cmd_mark = cmd_count;
  endtask

  task automatic end_test(input string name);
    $display("%s: %0d commands, %0d errors", name, cmd_count - cmd_mark,
             cmp_err + seq_err - err_mark);
  endtask

  initial begin
    int a;
    int d;
    int lk;
    int s;
    logic [31:0] rnd;
    rnd = $urandom(71);
    sys_rst    = 1'b1;
    i_wr_en    = 1'b0;
    i_wr_addr  = '0;
    i_wr_data  = '0;
    i_cmd_req  = 1'b0;
    i_cmd_addr = '0;
    i_cmd_dest = '0;
    i_cmd_dir  = '0;
    i_cmd_lk0  = 1'b0;
    i_cmd_seq  = '0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    sys_rst = 1'b0;

    for (a = 0; a < cb_pkg::CB_DEPTH; a++) begin
      write_row(a[cb_pkg::CB_AW-1:0], rand_row());
    end

    start_test();
    for (a = 0; a < cb_pkg::CB_DEPTH; a++) begin
      for (d = 1; d < 4; d++) begin
        run_cmd(a[5:0], d[1:0], cb_pkg::DIR_POS, 1'b0, '0, 3'd0);
        run_cmd(a[5:0], d[1:0], cb_pkg::DIR_NEG, 1'b1, '0, 3'd0);
      end
    end
    end_test("Test 1 positive and negative to A, B and M");

    start_test();
    for (a = 0; a < cb_pkg::CB_DEPTH; a += 4) begin
      for (d = 1; d < 4; d++) begin
        for (lk = 0; lk < 2; lk++) begin
          run_cmd(a[5:0], d[1:0], cb_pkg::DIR_NEW, lk[0], '0, 3'd0);
        end
      end
    end
    end_test("Test 2 new landmark to A, B and M");

    start_test();
    for (a = 0; a < cb_pkg::CB_DEPTH; a += 8) begin
      for (s = 0; s < 7; s++) begin
        for (lk = 0; lk < 2; lk++) begin
          run_cmd(a[5:0], cb_pkg::DEST_TB, cb_pkg::DIR_NEW, lk[0], s[9:0], 3'd0);
        end
      end
    end
    end_test("Test 3 new landmark steps to TB");

    start_test();
    for (a = 3; a < cb_pkg::CB_DEPTH; a += 8) begin
      for (d = 0; d < 4; d++) begin
        run_cmd(a[5:0], d[1:0], cb_pkg::DIR_IDLE, 1'b1, 10'd2, 3'd0);
      end
      run_cmd(a[5:0], cb_pkg::DEST_TB, cb_pkg::DIR_POS, 1'b0, 10'd2, 3'd0);
      run_cmd(a[5:0], cb_pkg::DEST_TB, cb_pkg::DIR_NEG, 1'b1, 10'd3, 3'd0);
    end
    end_test("Test 4 idle and TB zero cases");

    // Ack held for a growing number of cycles
    start_test();
    for (a = 0; a < 8; a++) begin
      rnd = $urandom;
      run_cmd(rnd[5:0], rnd[7:6], rnd[9:8], rnd[10], {7'd0, rnd[13:11]}, a[2:0]);
    end
    end_test("Test 5 handshake timing and release");

    start_test();
    for (a = 0; a < 200; a++) begin
      rnd = $urandom;
      if (rnd[17:16] == 2'd0) begin
        write_row(rnd[5:0], rand_row());
      end else if (rnd[17:16] == 2'd1) begin
        write_row(rnd[23:18], rand_row());
      end
      run_cmd(rnd[5:0], rnd[7:6], rnd[9:8], rnd[10], {7'd0, rnd[13:11]},
              {1'b0, rnd[15:14]});
    end
    end_test("Test 6 random commands with rewrites");

    $display("Summary: %0d commands, %0d output samples, %0d errors",
             cmd_count, cmp_count, cmp_err + seq_err);
    if (cmp_err + seq_err == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* verilog.f */
verilog/cb_pkg.sv
verilog/cb_read_sequencer.sv
verilog/cb_bank_ram.sv
verilog/cb_douta_map.sv
verilog/cb_read_top.sv
testbench/cb_read_top_chk.sv
testbench/tb_cb_read_top.sv

/* verilog/cb_bank_ram.sv */
`timescale 1ns/1ns

module cb_bank_ram (
  input  logic                        clk,

  // Row write port
  input  logic                        i_wr_en,
  input  logic [cb_pkg::CB_AW-1:0]    i_wr_addr,
  input  logic [cb_pkg::ROW_W-1:0]    i_wr_data,

  // Row read port with one cycle of latency
  input  logic                        i_rd_en,
  input  logic [cb_pkg::CB_AW-1:0]    i_rd_addr,
  output logic [cb_pkg::ROW_W-1:0]    o_rd_row
);

  // One bank per lane, all banks share the row address
  logic [cb_pkg::RSA_DW-1:0] bank_mem [cb_pkg::CB_L][cb_pkg::CB_DEPTH];

  // Each bank takes its own lane of the written row
  always_ff @(posedge clk) begin
    if (i_wr_en) begin
      for (int b = 0; b < cb_pkg::CB_L; b++) begin
        bank_mem[b][i_wr_addr] <= i_wr_data[b*cb_pkg::RSA_DW +: cb_pkg::RSA_DW];
      end
    end
  end

  // Read register keeps the last row until the next read
  // A read of the row being written returns the old contents
  always_ff @(posedge clk) begin
    if (i_rd_en) begin
      for (int b = 0; b < cb_pkg::CB_L; b++) begin
        o_rd_row[b*cb_pkg::RSA_DW +: cb_pkg::RSA_DW] <= bank_mem[b][i_rd_addr];
      end
    end
  end

endmodule

/* verilog/cb_douta_map.sv */
`timescale 1ns/1ns

module cb_douta_map (
  input  logic                                  clk,
  input  logic                                  sys_rst,

  // Select, aligned with the row
  input  logic [1:0]                            i_dest,
  input  logic [1:0]                            i_dir,
  input  logic                                  i_lk0,
  input  logic [cb_pkg::SEQ_CNT_DW-1:0]         i_seq,
  input  logic [cb_pkg::ROW_W-1:0]              i_rd_row,

  // Registered destination lanes
  output logic [cb_pkg::CB_X*cb_pkg::RSA_DW-1:0] o_tb_dina,
  output logic [cb_pkg::CB_X*cb_pkg::RSA_DW-1:0] o_a_douta,
  output logic [cb_pkg::CB_Y*cb_pkg::RSA_DW-1:0] o_b_douta,
  output logic [cb_pkg::CB_X*cb_pkg::RSA_DW-1:0] o_m_douta
);

  logic [cb_pkg::RSA_DW-1:0] lane_p0;
  logic [cb_pkg::RSA_DW-1:0] lane_p1;

  // Low landmark bit picks banks 0/1 or banks 2/3
  assign lane_p0 = i_lk0 ? i_rd_row[0 +: cb_pkg::RSA_DW]
                         : i_rd_row[2*cb_pkg::RSA_DW +: cb_pkg::RSA_DW];
  assign lane_p1 = i_lk0 ? i_rd_row[1*cb_pkg::RSA_DW +: cb_pkg::RSA_DW]
                         : i_rd_row[3*cb_pkg::RSA_DW +: cb_pkg::RSA_DW];

  // Common mapping for the A, B and M operands
  function automatic logic [cb_pkg::ROW_W-1:0] map_abm(
    input logic [1:0]                dir,
    input logic [cb_pkg::ROW_W-1:0]  row,
    input logic [cb_pkg::RSA_DW-1:0] p0,
    input logic [cb_pkg::RSA_DW-1:0] p1
  );
    logic [cb_pkg::ROW_W-1:0] res;
    res = '0;
    case (dir)
      cb_pkg::DIR_POS: res = row;
      cb_pkg::DIR_NEG: begin
        for (int k = 0; k < cb_pkg::CB_L; k++) begin
          res[k*cb_pkg::RSA_DW +: cb_pkg::RSA_DW] =
            row[(cb_pkg::CB_L-1-k)*cb_pkg::RSA_DW +: cb_pkg::RSA_DW];
        end
      end
      cb_pkg::DIR_NEW: begin
        // Pair lands in the bottom two lanes, upper lanes stay clear
        res[0 +: cb_pkg::RSA_DW]                = p0;
        res[cb_pkg::RSA_DW +: cb_pkg::RSA_DW]   = p1;
      end
      default: res = '0;
    endcase
    return res;
  endfunction

  // Transfer buffer layout per new-landmark step
  function automatic logic [cb_pkg::ROW_W-1:0] map_tb(
    input logic [1:0]                    dir,
    input logic [cb_pkg::SEQ_CNT_DW-1:0] seq,
    input logic [cb_pkg::RSA_DW-1:0]     p0,
    input logic [cb_pkg::RSA_DW-1:0]     p1
  );
    logic [cb_pkg::ROW_W-1:0] res;
    res = '0;
    if (dir == cb_pkg::DIR_NEW) begin
      case (int'(seq))
        0: res[3*cb_pkg::RSA_DW +: cb_pkg::RSA_DW] = p1;
        1: res[0 +: cb_pkg::RSA_DW] = p0;
        2: begin
          res[0 +: cb_pkg::RSA_DW]              = p1;
          res[1*cb_pkg::RSA_DW +: cb_pkg::RSA_DW] = p0;
        end
        3: begin
          res[1*cb_pkg::RSA_DW +: cb_pkg::RSA_DW] = p1;
          res[2*cb_pkg::RSA_DW +: cb_pkg::RSA_DW] = p0;
        end
        4: begin
          res[2*cb_pkg::RSA_DW +: cb_pkg::RSA_DW] = p1;
          res[3*cb_pkg::RSA_DW +: cb_pkg::RSA_DW] = p0;
        end
        default: res = '0;
      endcase
    end
    return res;
  endfunction

  // TB destination
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      o_tb_dina <= '0;
    end else if (i_dest == cb_pkg::DEST_TB) begin
      o_tb_dina <= map_tb(i_dir, i_seq, lane_p0, lane_p1);
    end else begin
      o_tb_dina <= '0;
    end
  end

  // Operand A
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      o_a_douta <= '0;
    end else if (i_dest == cb_pkg::DEST_A) begin
      o_a_douta <= map_abm(i_dir, i_rd_row, lane_p0, lane_p1);
    end else begin
      o_a_douta <= '0;
    end
  end

  // Operand B
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      o_b_douta <= '0;
    end else if (i_dest == cb_pkg::DEST_B) begin
      o_b_douta <= map_abm(i_dir, i_rd_row, lane_p0, lane_p1);
    end else begin
      o_b_douta <= '0;
    end
  end

  // Operand M
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      o_m_douta <= '0;
    end else if (i_dest == cb_pkg::DEST_M) begin
      o_m_douta <= map_abm(i_dir, i_rd_row, lane_p0, lane_p1);
    end else begin
      o_m_douta <= '0;
    end
  end

endmodule

/* verilog/cb_pkg.sv */
package cb_pkg;

  // Row geometry of the covariance buffer
  localparam int unsigned CB_L = 4;
  localparam int unsigned CB_X = 4;
  localparam int unsigned CB_Y = 4;

  // Lane width and sequence step width
  localparam int unsigned RSA_DW = 16;
  localparam int unsigned SEQ_CNT_DW = 10;

  // Row addressing
  localparam int unsigned CB_AW = 6;
  localparam int unsigned CB_DEPTH = 64;

  // One full row holds every lane side by side, lane 0 in the low bits
  localparam int unsigned ROW_W = CB_L * RSA_DW;

  // Destination of a read
  localparam logic [1:0] DEST_TB = 2'd0;
  localparam logic [1:0] DEST_A = 2'd1;
  localparam logic [1:0] DEST_B = 2'd2;
  localparam logic [1:0] DEST_M = 2'd3;

  // Lane mapping direction
  // NEW picks a lane pair from the low landmark bit
  localparam logic [1:0] DIR_IDLE = 2'd0;
  localparam logic [1:0] DIR_POS = 2'd1;
  localparam logic [1:0] DIR_NEG = 2'd2;
  localparam logic [1:0] DIR_NEW = 2'd3;

  // Read sequencer states
  localparam logic [2:0] ST_IDLE = 3'd0;
  localparam logic [2:0] ST_READ = 3'd1;
  localparam logic [2:0] ST_SETTLE = 3'd2;
  localparam logic [2:0] ST_ACK = 3'd3;
  localparam logic [2:0] ST_RELEASE = 3'd4;

endpackage

/* verilog/cb_read_sequencer.sv */
`timescale 1ns/1ns

module cb_read_sequencer (
  input  logic                            clk,
  input  logic                            sys_rst,

  // Four-phase command port
  input  logic                            i_cmd_req,
  input  logic [cb_pkg::CB_AW-1:0]        i_cmd_addr,
  input  logic [1:0]                      i_cmd_dest,
  input  logic [1:0]                      i_cmd_dir,
  input  logic                            i_cmd_lk0,
  input  logic [cb_pkg::SEQ_CNT_DW-1:0]   i_cmd_seq,
  output logic                            o_cmd_ack,

  // Buffer read
  output logic                            o_rd_en,
  output logic [cb_pkg::CB_AW-1:0]        o_rd_addr,

  // Mapper select, aligned with the registered row
  output logic [1:0]                      o_map_dest,
  output logic [1:0]                      o_map_dir,
  output logic                            o_map_lk0,
  output logic [cb_pkg::SEQ_CNT_DW-1:0]   o_map_seq
);

  logic [2:0]                    state;
  logic [1:0]                    cmd_dest;
  logic [1:0]                    cmd_dir;
  logic                          cmd_lk0;
  logic [cb_pkg::SEQ_CNT_DW-1:0] cmd_seq;
  logic                          cmd_take;
  logic                          sel_live;

  assign cmd_take = (state == cb_pkg::ST_IDLE) && i_cmd_req;

  // Select follows the command from the row arrival until release ends
  assign sel_live = (state == cb_pkg::ST_SETTLE) ||
                    (state == cb_pkg::ST_ACK) ||
                    (state == cb_pkg::ST_RELEASE);

  // Handshake FSM
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      state     <= cb_pkg::ST_IDLE;
      o_cmd_ack <= 1'b0;
      o_rd_en   <= 1'b0;
    end else begin
      case (state)
        cb_pkg::ST_IDLE: begin
          if (i_cmd_req) begin
            state <= cb_pkg::ST_READ;
          end
        end
        cb_pkg::ST_READ: begin
          // One-cycle read pulse toward the banks
          o_rd_en <= 1'b1;
          state   <= cb_pkg::ST_SETTLE;
        end
        cb_pkg::ST_SETTLE: begin
          o_rd_en <= 1'b0;
          state   <= cb_pkg::ST_ACK;
        end
        cb_pkg::ST_ACK: begin
          o_cmd_ack <= 1'b1;
          // Hold here for as long as the requester keeps req up
          if (o_cmd_ack && !i_cmd_req) begin
            state <= cb_pkg::ST_RELEASE;
          end
        end
        cb_pkg::ST_RELEASE: begin
          o_cmd_ack <= 1'b0;
          state     <= cb_pkg::ST_IDLE;
        end
        default: begin
          o_cmd_ack <= 1'b0;
          o_rd_en   <= 1'b0;
          state     <= cb_pkg::ST_IDLE;
        end
      endcase
    end
  end

  // Command fields are stable while req is high, so one capture is enough
  always_ff @(posedge clk) begin
    if (cmd_take) begin
      o_rd_addr <= i_cmd_addr;
      cmd_dest  <= i_cmd_dest;
      cmd_dir   <= i_cmd_dir;
      cmd_lk0   <= i_cmd_lk0;
      cmd_seq   <= i_cmd_seq;
    end
  end

  // Select stage one cycle behind the read
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      o_map_dest <= cb_pkg::DEST_TB;
      o_map_dir  <= cb_pkg::DIR_IDLE;
      o_map_lk0  <= 1'b0;
      o_map_seq  <= '0;
    end else if (sel_live) begin
      o_map_dest <= cmd_dest;
      o_map_dir  <= cmd_dir;
      o_map_lk0  <= cmd_lk0;
      o_map_seq  <= cmd_seq;
    end else begin
      // Idle direction makes every mapper output zero
      o_map_dir <= cb_pkg::DIR_IDLE;
    end
  end

endmodule

/* verilog/cb_read_top.sv */
`timescale 1ns/1ns

module cb_read_top (
  input  logic                                  clk,
  input  logic                                  sys_rst,

  // Row write port
  input  logic                                  i_wr_en,
  input  logic [cb_pkg::CB_AW-1:0]              i_wr_addr,
  input  logic [cb_pkg::ROW_W-1:0]              i_wr_data,

  // Read command port
  input  logic                                  i_cmd_req,
  input  logic [cb_pkg::CB_AW-1:0]              i_cmd_addr,
  input  logic [1:0]                            i_cmd_dest,
  input  logic [1:0]                            i_cmd_dir,
  input  logic                                  i_cmd_lk0,
  input  logic [cb_pkg::SEQ_CNT_DW-1:0]         i_cmd_seq,
  output logic                                  o_cmd_ack,

  // Mapped lanes
  output logic [cb_pkg::CB_X*cb_pkg::RSA_DW-1:0] o_tb_dina,
  output logic [cb_pkg::CB_X*cb_pkg::RSA_DW-1:0] o_a_douta,
  output logic [cb_pkg::CB_Y*cb_pkg::RSA_DW-1:0] o_b_douta,
  output logic [cb_pkg::CB_X*cb_pkg::RSA_DW-1:0] o_m_douta
);

  logic                          rd_en;
  logic [cb_pkg::CB_AW-1:0]      rd_addr;
  logic [cb_pkg::ROW_W-1:0]      rd_row;
  logic [1:0]                    map_dest;
  logic [1:0]                    map_dir;
  logic                          map_lk0;
  logic [cb_pkg::SEQ_CNT_DW-1:0] map_seq;

  cb_read_sequencer u_seq (
    .clk        (clk),
    .sys_rst    (sys_rst),
    .i_cmd_req  (i_cmd_req),
    .i_cmd_addr (i_cmd_addr),
    .i_cmd_dest (i_cmd_dest),
    .i_cmd_dir  (i_cmd_dir),
    .i_cmd_lk0  (i_cmd_lk0),
    .i_cmd_seq  (i_cmd_seq),
    .o_cmd_ack  (o_cmd_ack),
    .o_rd_en    (rd_en),
    .o_rd_addr  (rd_addr),
    .o_map_dest (map_dest),
    .o_map_dir  (map_dir),
    .o_map_lk0  (map_lk0),
    .o_map_seq  (map_seq)
  );

  cb_bank_ram u_ram (
    .clk       (clk),
    .i_wr_en   (i_wr_en),
    .i_wr_addr (i_wr_addr),
    .i_wr_data (i_wr_data),
    .i_rd_en   (rd_en),
    .i_rd_addr (rd_addr),
    .o_rd_row  (rd_row)
  );

  cb_douta_map u_map (
    .clk       (clk),
    .sys_rst   (sys_rst),
    .i_dest    (map_dest),
    .i_dir     (map_dir),
    .i_lk0     (map_lk0),
    .i_seq     (map_seq),
    .i_rd_row  (rd_row),
    .o_tb_dina (o_tb_dina),
    .o_a_douta (o_a_douta),
    .o_b_douta (o_b_douta),
    .o_m_douta (o_m_douta)
  );

endmodule
